/* hdl/beam_num_pkg.sv */
// numeric formats used by the beamformer datapath
// covers sample, weight and partial product widths and the scaling shift
`default_nettype none

package beam_num_pkg;

    // one real or imaginary part of an input sample, two's complement
    localparam int SAMPLE_WIDTH = 16;

    // one real or imaginary part of a channel weight, two's complement
    localparam int WEIGHT_WIDTH = 8;

    // the weight is a fraction with this many bits after the binary point,
    // so each product is shifted down by the same amount
    localparam int WEIGHT_FRAC_BITS = 8;

    // a full sample times weight product fits in this many bits without loss
    localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + WEIGHT_WIDTH;

    // signed sample part, also the width of every result lane
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // signed weight part, the range includes -128 and 127
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // signed partial product before scaling
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

/* hdl/beam_array_pkg.sv */
// array geometry of the beamformer
// holds channel and lane counts, pipeline depth and the lane vector types
`default_nettype none

package beam_array_pkg;

    // number of antenna channels that are weighted and summed
    localparam int NUM_CHANNELS = 4;

    // complex samples per beat in every channel
    localparam int LANES = 8;

    // register stages between the accepting edge and the output register
    localparam int PIPE_DEPTH = 3;

    // one beat of one channel, one sample part per lane (128 bits)
    typedef beam_num_pkg::sample_t [LANES-1:0] lane_vec_t;

    // one beat of all channels (512 bits)
    typedef lane_vec_t [NUM_CHANNELS-1:0] chan_lanes_t;

    // one weight part per channel (32 bits)
    typedef beam_num_pkg::weight_t [NUM_CHANNELS-1:0] chan_weights_t;

endpackage

`default_nettype wire

/* hdl/beam_pipe_ctrl.sv */
// pipeline control for the beamformer
// joins the channel valids, drives the shared ready and the stage enable,
// and carries valid and last through the pipeline stages
`timescale 1ns/10ps
`default_nettype none

module beam_pipe_ctrl (
    input  logic                                  clock,
    input  logic                                  resetn,
    input  logic [beam_array_pkg::NUM_CHANNELS-1:0] in_valid,
    input  logic                                  in_last,
    input  logic                                  out_ready,
    output logic                                  in_ready,
    output logic                                  advance,
    output logic                                  out_valid,
    output logic                                  out_last
);

    import beam_array_pkg::*;

    // one bit per register stage, index 0 is the first stage after the input
    logic [PIPE_DEPTH-1:0] valid_q;
    logic [PIPE_DEPTH-1:0] last_q;

    // a beat only counts once every channel offers its part
    logic all_valid;

    assign all_valid = &in_valid;

    // the pipeline moves when the output register is free or being drained
    // this is the only stall condition in the design, every stage shares it
    assign advance = !valid_q[PIPE_DEPTH-1] || out_ready;

    // ready is taken from the stall state only, never from in_valid,
    // so a sender may wait for ready before raising its valid
    assign in_ready = advance;

    // the tracking bits shift one stage on every advance
    // a missing input beat enters as a bubble with a cleared valid bit
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q <= '0;
            last_q  <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[PIPE_DEPTH-2:0], all_valid};
            last_q  <= {last_q[PIPE_DEPTH-2:0], all_valid && in_last};
        end
    end

    // the last stage lines up with the output data register in beam_sum
    assign out_valid = valid_q[PIPE_DEPTH-1];
    assign out_last  = last_q[PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* hdl/complex_weight.sv */
// complex weighting of one channel
// multiplies every lane of a beat by the channel's complex weight in two
// register stages, scaling each partial product by the weight fraction
`timescale 1ns/10ps
`default_nettype none

module complex_weight (
    input  logic                      clock,
    input  logic                      advance,
    input  beam_array_pkg::lane_vec_t in_re,
    input  beam_array_pkg::lane_vec_t in_im,
    input  beam_num_pkg::weight_t     weight_re,
    input  beam_num_pkg::weight_t     weight_im,
    output beam_array_pkg::lane_vec_t prod_re,
    output beam_array_pkg::lane_vec_t prod_im
);

    import beam_num_pkg::*;
    import beam_array_pkg::*;

    // scaled partial products of the first stage, one sample per lane
    //   rr = re * w_re, ii = im * w_im, ri = im * w_re, ir = re * w_im
    lane_vec_t rr_q;
    lane_vec_t ii_q;
    lane_vec_t ri_q;
    lane_vec_t ir_q;

    // full precision product, then an arithmetic shift by the fraction bits
    // the shifted value is cut back to a sample, so both parts of the
    // result follow exactly the same rule
    function automatic sample_t scaled_product(input sample_t smp, input weight_t wgt);
        product_t full;
        full = product_t'(smp) * product_t'(wgt);
        return sample_t'(full >>> WEIGHT_FRAC_BITS);
    endfunction

    // stage one
    // the weight is sampled on the same edge as the lanes, so each weight
    // stays tied to the beat it came with
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int lane = 0; lane < LANES; lane++) begin
                rr_q[lane] <= scaled_product(in_re[lane], weight_re);
                ii_q[lane] <= scaled_product(in_im[lane], weight_im);
                ri_q[lane] <= scaled_product(in_im[lane], weight_re);
                ir_q[lane] <= scaled_product(in_re[lane], weight_im);
            end
        end
    end

    // stage two
    // real part is rr minus ii and imaginary part is ri plus ir,
    // both wrap at the sample width
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int lane = 0; lane < LANES; lane++) begin
                prod_re[lane] <= rr_q[lane] - ii_q[lane];
                prod_im[lane] <= ri_q[lane] + ir_q[lane];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/beam_sum.sv */
// cross-channel summation
// adds the weighted channels lane by lane into the output data register
`timescale 1ns/10ps
`default_nettype none

module beam_sum (
    input  logic                        clock,
    input  logic                        advance,
    input  beam_array_pkg::chan_lanes_t chan_re,
    input  beam_array_pkg::chan_lanes_t chan_im,
    output beam_array_pkg::lane_vec_t   out_re,
    output beam_array_pkg::lane_vec_t   out_im
);

    import beam_array_pkg::*;

    // combinational lane sums ahead of the output register
    lane_vec_t sum_re;
    lane_vec_t sum_im;

    // sums are kept at the sample width on purpose, the output wraps
    // just like the per channel results do
    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int chan = 0; chan < NUM_CHANNELS; chan++) begin
            for (int lane = 0; lane < LANES; lane++) begin
                sum_re[lane] = sum_re[lane] + chan_re[chan][lane];
                sum_im[lane] = sum_im[lane] + chan_im[chan][lane];
            end
        end
    end

    // output register, it holds its beat while the pipeline is stalled
    // which keeps the output data steady under back-pressure
    always_ff @(posedge clock) begin
        if (advance) begin
            out_re <= sum_re;
            out_im <= sum_im;
        end
    end

endmodule

`default_nettype wire

/* hdl/beamformer_top.sv */
// top level of the four-channel complex beamformer
// wires the pipeline controller, one weighter per channel and the summer
`timescale 1ns/10ps
`default_nettype none

module beamformer_top (
    input  logic                                    clock,
    input  logic                                    resetn,
    input  logic [beam_array_pkg::NUM_CHANNELS-1:0] in_valid,
    output logic                                    in_ready,
    input  beam_array_pkg::chan_lanes_t             in_re,
    input  beam_array_pkg::chan_lanes_t             in_im,
    input  beam_array_pkg::chan_weights_t           weight_re,
    input  beam_array_pkg::chan_weights_t           weight_im,
    input  logic                                    in_last,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output beam_array_pkg::lane_vec_t               out_re,
    output beam_array_pkg::lane_vec_t               out_im,
    output logic                                    out_last
);

    import beam_array_pkg::*;

    // shared stage enable, every data register loads on it
    logic advance;

    // weighted lanes of all channels, input to the summer
    chan_lanes_t chan_re;
    chan_lanes_t chan_im;

    // valid, last and stall handling
    beam_pipe_ctrl u_ctrl (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .advance   (advance),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    // one weighter per channel, the two stages match the controller's
    // first two tracking bits
    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
        complex_weight u_weight (
            .clock     (clock),
            .advance   (advance),
            .in_re     (in_re[c]),
            .in_im     (in_im[c]),
            .weight_re (weight_re[c]),
            .weight_im (weight_im[c]),
            .prod_re   (chan_re[c]),
            .prod_im   (chan_im[c])
        );
    end

    // third stage, the output register
    beam_sum u_sum (
        .clock   (clock),
        .advance (advance),
        .chan_re (chan_re),
        .chan_im (chan_im),
        .out_re  (out_re),
        .out_im  (out_im)
    );

endmodule

`default_nettype wire

/* testbench/beamformer_chk.sv */
// protocol checks on the beamformer top level, attached with bind
// output clear in reset and before the first beat can arrive, fixed latency
// with the output open, and stable output under back-pressure
`timescale 1ns/10ps
`default_nettype none

module beamformer_chk (
    input logic                                    clock,
    input logic                                    resetn,
    input logic [beam_array_pkg::NUM_CHANNELS-1:0] in_valid,
    input logic                                    in_ready,
    input logic                                    out_valid,
    input logic                                    out_ready,
    input beam_array_pkg::lane_vec_t               out_re,
    input beam_array_pkg::lane_vec_t               out_im,
    input logic                                    out_last
);

    import beam_array_pkg::*;

    // an input beat is taken on this edge
    logic accepted;
    // set once the first beat since reset has gone in
    logic accept_seen;

    assign accepted = &in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            accept_seen <= 1'b0;
        end else if (accepted) begin
            accept_seen <= 1'b1;
        end
    end

    // every reset cycle leaves the output side empty
    reset_clear: assert property (@(posedge clock) !resetn |=> !out_valid && !out_last)
        else $error("out_valid or out_last high after a reset cycle");

    // the first beat needs the full pipeline depth to reach the output
    no_early_output: assert property (@(posedge clock) disable iff (!resetn)
        (out_valid || out_last) |-> $past(accept_seen, PIPE_DEPTH - 1))
        else $error("output became valid before a beat could have passed the pipeline");

    // with out_ready high the pipeline never stalls, three cycles exactly
    fixed_latency: assert property (@(posedge clock) disable iff (!resetn)
        accepted ##1 out_ready ##1 out_ready |=> out_valid)
        else $error("out_valid missing three cycles after an accepted beat");

    // a beat waiting on out_ready keeps its data and flags
    hold_on_stall: assert property (@(posedge clock) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_re) && $stable(out_im)
            && $stable(out_last))
        else $error("output beat changed while stalled by out_ready");

endmodule

bind beamformer_top beamformer_chk u_chk (
    .clock     (clock),
    .resetn    (resetn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_re    (out_re),
    .out_im    (out_im),
    .out_last  (out_last)
);

`default_nettype wire

/* testbench/beamformer_tb.sv */
// testbench for the four-channel complex beamformer
// random joined-valid stimulus with output back-pressure, a reference model
// of the weighting and summation, and an in-order scoreboard of output beats
`timescale 1ns/10ps
`default_nettype none

module beamformer_tb;

    import beam_num_pkg::*;
    import beam_array_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_BEATS    = 200;
    // 200 beats at worst about 8 cycles each, plus reset, rounded up
    localparam int TIMEOUT_CYCLES = 2000;

    // one expected output beat as the scoreboard keeps it
    typedef struct packed {
        lane_vec_t re;
        lane_vec_t im;
        logic      last;
    } beat_t;

    logic                    clock     = 1'b0;
    logic                    resetn    = 1'b0;
    logic [NUM_CHANNELS-1:0] in_valid  = '0;
    logic                    in_ready;
    chan_lanes_t             in_re     = '0;
    chan_lanes_t             in_im     = '0;
    chan_weights_t           weight_re = '0;
    chan_weights_t           weight_im = '0;
    logic                    in_last   = 1'b0;
    logic                    out_valid;
    logic                    out_ready = 1'b0;
    lane_vec_t               out_re;
    lane_vec_t               out_im;
    logic                    out_last;

    integer seed     = 53;
    int     cycles   = 0;
    int     accepted = 0;
    int     received = 0;
    beat_t  expected_q[$];

    beamformer_top DUT (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_re     (in_re),
        .in_im     (in_im),
        .weight_re (weight_re),
        .weight_im (weight_im),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_last  (out_last)
    );

    always #10 clock = ~clock;

    // weights hit both ends of their range now and then
    function automatic weight_t pick_weight();
        int pick;
        pick = {$random(seed)} % 8;
        if (pick == 0) begin
            return weight_t'(8'h80);
        end else if (pick == 1) begin
            return weight_t'(8'h7f);
        end
        return weight_t'($random(seed));
    endfunction

    // new data and weights, with only some of the channel valids raised so far
    task automatic start_beat();
        chan_lanes_t   re;
        chan_lanes_t   im;
        chan_weights_t wr;
        chan_weights_t wi;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int l = 0; l < LANES; l++) begin
                re[c][l] = sample_t'($random(seed));
                im[c][l] = sample_t'($random(seed));
            end
            wr[c] = pick_weight();
            wi[c] = pick_weight();
        end
        in_re     <= re;
        in_im     <= im;
        weight_re <= wr;
        weight_im <= wi;
        in_last   <= 1'($random(seed));
        in_valid  <= NUM_CHANNELS'($random(seed));
    endtask

    // each part is scaled on its own, the 16-bit wrap is taken once at the
    // end, which gives the same low bits as wrapping after every step
    function automatic beat_t model_beat();
        beat_t   beat;
        int      acc_re;
        int      acc_im;
        int      sr;
        int      si;
        int      wr;
        int      wi;
        sample_t s;
        weight_t w;
        for (int l = 0; l < LANES; l++) begin
            acc_re = 0;
            acc_im = 0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                s  = in_re[c][l];
                sr = int'(s);
                s  = in_im[c][l];
                si = int'(s);
                w  = weight_re[c];
                wr = int'(w);
                w  = weight_im[c];
                wi = int'(w);
                acc_re += ((sr * wr) >>> WEIGHT_FRAC_BITS) - ((si * wi) >>> WEIGHT_FRAC_BITS);
                acc_im += ((si * wr) >>> WEIGHT_FRAC_BITS) + ((sr * wi) >>> WEIGHT_FRAC_BITS);
            end
            beat.re[l] = acc_re[15:0];
            beat.im[l] = acc_im[15:0];
        end
        beat.last = in_last;
        return beat;
    endfunction

    task automatic report_mismatch(input string name, input string exp_s, input string act_s);
        $display("[FAIL] %s expected %s actual %s", name, exp_s, act_s);
        $display("TB FAILED");
        $fatal(1, "output beat mismatch");
    endtask

    // every transfer must match the oldest accepted beat
    task automatic check_output();
        beat_t exp;
        if (expected_q.size() == 0) begin
            $display("output beat %0d arrived with no accepted input beat waiting", received);
            $display("TB FAILED");
            $fatal(1, "unexpected output beat");
        end else begin
            exp = expected_q.pop_front();
            assert (out_re == exp.re)
                else report_mismatch($sformatf("beat %0d real lanes", received),
                                     $sformatf("%h", exp.re), $sformatf("%h", out_re));
            assert (out_im == exp.im)
                else report_mismatch($sformatf("beat %0d imag lanes", received),
                                     $sformatf("%h", exp.im), $sformatf("%h", out_im));
            assert (out_last == exp.last)
                else report_mismatch($sformatf("beat %0d last", received),
                                     $sformatf("%b", exp.last), $sformatf("%b", out_last));
            received++;
        end
    endtask

    // one process drives every input, so the reset release, the stimulus
    // and the scoreboard all see the same edge
    always @(posedge clock) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles, %0d of %0d beats received",
                     TIMEOUT_CYCLES, received, NUM_BEATS);
            $display("TB FAILED");
            $fatal(1, "simulation timed out");
        end else if (!resetn) begin
            if (cycles == RESET_CYCLES) begin
                resetn <= 1'b1;
                start_beat();
            end
        end else begin
            if (out_valid && out_ready) begin
                check_output();
            end
            // the model reads the same pre-edge values the DUT samples
            if (&in_valid && in_ready) begin
                expected_q.push_back(model_beat());
                accepted++;
                if (accepted < NUM_BEATS) begin
                    start_beat();
                end else begin
                    in_valid <= '0;
                end
            end else if (accepted < NUM_BEATS) begin
                // missing channel valids come up one by one at random
                in_valid <= in_valid | NUM_CHANNELS'($random(seed));
            end
            // out_ready is low about 30% of the time
            out_ready <= ({$random(seed)} % 10) >= 3;
            if (received == NUM_BEATS && expected_q.size() == 0) begin
                $display("TB PASSED");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

/* files.f */
hdl/beam_num_pkg.sv
hdl/beam_array_pkg.sv
hdl/beam_pipe_ctrl.sv
hdl/complex_weight.sv
hdl/beam_sum.sv
hdl/beamformer_top.sv
testbench/beamformer_chk.sv
testbench/beamformer_tb.sv

/* Makefile */
# Verilator build and run of the beamformer testbench
# the exit status of the simulation binary is the test result

VERILATOR ?= verilator
VFLAGS    ?= -j 0
TOP       ?= beamformer_tb
BUILD_DIR ?= build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build from files.f with Verilator and run the simulation"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR VFLAGS TOP BUILD_DIR"

test:
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f files.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
